// File: source/aib_csr_config.svh
//////////////////////////////
// Adapter CSR address width, register
// offsets, readback masks and boot values
//////////////////////////////

`ifndef AIB_CSR_CONFIG_SVH
`define AIB_CSR_CONFIG_SVH

// Bus address width
`define AIB_CSR_AW 7

// Register offsets
`define AIB_CSR_RX0_ADDR 7'h08
`define AIB_CSR_RX1_ADDR 7'h10
`define AIB_CSR_TX0_ADDR 7'h18
`define AIB_CSR_TX1_ADDR 7'h1c

// Implemented bits of each word
`define AIB_CSR_RX0_MASK 32'h0700_0002
`define AIB_CSR_RX1_MASK 32'h0000_0007
`define AIB_CSR_TX0_MASK 32'hf0e0_0002
`define AIB_CSR_TX1_MASK 32'h0000_c000

// Defaults written by the boot loader
`define AIB_CSR_RX0_BOOT 32'h1500_0a02
`define AIB_CSR_RX1_BOOT 32'h0000_0105
`define AIB_CSR_TX0_BOOT 32'ha0c0_3402
`define AIB_CSR_TX1_BOOT 32'h0000_8c01

`endif

// File: source/aib_csr_pkg.sv
//////////////////////////////
// Bus request, bus response and
// adapter configuration types
//////////////////////////////

`default_nettype none

`include "aib_csr_config.svh"

package aib_csr_pkg;

   // One request on the shared register bus
   typedef struct packed {
      logic                   write;
      logic                   read;
      logic [`AIB_CSR_AW-1:0] address;
      logic [31:0]            writedata;
      logic [3:0]             byteenable;
   } avmm_req_t;

   // Read response, one cycle after the read strobe
   typedef struct packed {
      logic [31:0] readdata;
      logic        readdatavalid;
   } avmm_rsp_t;

   // Adapter control words towards the datapath
   typedef struct packed {
      logic [31:0] rx_0;
      logic [31:0] rx_1;
      logic [31:0] tx_0;
      logic [31:0] tx_1;
   } aib_adapt_cfg_t;

endpackage

`default_nettype wire

// File: source/axil_avmm_bridge.sv
//////////////////////////////
// AXI4-Lite slave to single
// register bus requests
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aib_csr_config.svh"

module axil_avmm_bridge (
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic [`AIB_CSR_AW-1:0]  awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [31:0]             wdata,
   input  logic [3:0]              wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic [`AIB_CSR_AW-1:0]  araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [31:0]             rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,
   output aib_csr_pkg::avmm_req_t  req,
   input  logic                    gnt,
   input  aib_csr_pkg::avmm_rsp_t  rsp
);

   import aib_csr_pkg::*;

   typedef enum logic [1:0] {st_idle, st_bus, st_rd_wait, st_resp} state_t;

   state_t    state;
   avmm_req_t req_q;
   logic      take_wr;
   logic      take_rd;

   // Writes win over a pending read
   assign take_wr = (state == st_idle) && awvalid && wvalid;
   assign take_rd = (state == st_idle) && arvalid && !(awvalid && wvalid);

   assign awready = take_wr;
   assign wready  = take_wr;
   assign arready = take_rd;

   // Request is presented only while waiting for the grant
   assign req = (state == st_bus) ? req_q : '0;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (take_wr || take_rd) begin
                  state <= st_bus;
               end
            end
            st_bus: begin
               if (gnt) begin
                  state <= req_q.write ? st_resp : st_rd_wait;
               end
            end
            st_rd_wait: begin
               if (rsp.readdatavalid) begin
                  state <= st_resp;
               end
            end
            default: begin
               if ((bvalid && bready) || (rvalid && rready)) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   // Captured transaction and read data
   always_ff @(posedge clk) begin
      if (take_wr) begin
         req_q <= '{write: 1'b1, read: 1'b0, address: awaddr,
                    writedata: wdata, byteenable: wstrb};
      end else if (take_rd) begin
         req_q <= '{write: 1'b0, read: 1'b1, address: araddr,
                    writedata: 32'h0, byteenable: 4'h0};
      end
      if (state == st_rd_wait && rsp.readdatavalid) begin
         rdata <= rsp.readdata;
      end
   end

   assign bvalid = (state == st_resp) && req_q.write;
   assign rvalid = (state == st_resp) && !req_q.write;
   // Always OKAY
   assign bresp  = 2'b00;
   assign rresp  = 2'b00;

   a_bvalid_hold : assert property (@(posedge clk) disable iff (!reset_n)
      bvalid && !bready |=> bvalid);
   a_rvalid_hold : assert property (@(posedge clk) disable iff (!reset_n)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// File: source/cfg_boot_loader.sv
//////////////////////////////
// Writes the boot values to the
// four adapter registers after reset
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aib_csr_config.svh"

module cfg_boot_loader (
   input  logic                   clk,
   input  logic                   reset_n,
   output aib_csr_pkg::avmm_req_t req,
   input  logic                   gnt,
   output logic                   cfg_done
);

   logic [1:0]             idx;
   logic [`AIB_CSR_AW-1:0] boot_addr;
   logic [31:0]            boot_data;

   // Boot table, in write order
   always_comb begin
      case (idx)
         2'd0: begin
            boot_addr = `AIB_CSR_RX0_ADDR;
            boot_data = `AIB_CSR_RX0_BOOT;
         end
         2'd1: begin
            boot_addr = `AIB_CSR_RX1_ADDR;
            boot_data = `AIB_CSR_RX1_BOOT;
         end
         2'd2: begin
            boot_addr = `AIB_CSR_TX0_ADDR;
            boot_data = `AIB_CSR_TX0_BOOT;
         end
         default: begin
            boot_addr = `AIB_CSR_TX1_ADDR;
            boot_data = `AIB_CSR_TX1_BOOT;
         end
      endcase
   end

   // Full-word write held until granted
   assign req = '{write: !cfg_done, read: 1'b0, address: boot_addr,
                  writedata: boot_data, byteenable: 4'hf};

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         idx      <= 2'd0;
         cfg_done <= 1'b0;
      end else if (gnt && !cfg_done) begin
         idx <= idx + 2'd1;
         // Last entry granted
         if (idx == 2'd3) begin
            cfg_done <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/avmm_arbiter.sv
//////////////////////////////
// Round-robin arbiter for the host
// bridge and the boot loader
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module avmm_arbiter (
   input  logic                   clk,
   input  logic                   reset_n,
   input  aib_csr_pkg::avmm_req_t host_req,
   input  aib_csr_pkg::avmm_req_t boot_req,
   output logic                   host_gnt,
   output logic                   boot_gnt,
   output aib_csr_pkg::avmm_req_t bus_req,
   input  aib_csr_pkg::avmm_rsp_t rsp
);

   logic host_vld;
   logic boot_vld;
   logic last_boot;
   logic busy;

   assign host_vld = host_req.read | host_req.write;
   assign boot_vld = boot_req.read | boot_req.write;

   // Either master wins when alone or when the other one won last time
   assign host_gnt = !busy && host_vld && (!boot_vld || last_boot);
   assign boot_gnt = !busy && boot_vld && (!host_vld || !last_boot);

   // Granted request is on the bus for its grant cycle only
   always_comb begin
      if (host_gnt) begin
         bus_req = host_req;
      end else if (boot_gnt) begin
         bus_req = boot_req;
      end else begin
         bus_req = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         last_boot <= 1'b0;
         busy      <= 1'b0;
      end else begin
         if (host_gnt || boot_gnt) begin
            last_boot <= boot_gnt;
         end
         // Bus stays owned until the read data returns
         if ((host_gnt || boot_gnt) && bus_req.read) begin
            busy <= 1'b1;
         end else if (rsp.readdatavalid) begin
            busy <= 1'b0;
         end
      end
   end

   a_one_gnt : assert property (@(posedge clk) disable iff (!reset_n)
      !(host_gnt && boot_gnt));
   a_no_gnt_busy : assert property (@(posedge clk) disable iff (!reset_n)
      bus_req.read |=> !(host_gnt || boot_gnt));

endmodule

`default_nettype wire

// File: source/aib_avmm_adapt_csr.sv
//////////////////////////////
// Four byte-enabled adapter control
// registers with masked readback
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aib_csr_config.svh"

module aib_avmm_adapt_csr (
   input  logic                        clk,
   input  logic                        reset_n,
   input  aib_csr_pkg::avmm_req_t      bus_req,
   output aib_csr_pkg::avmm_rsp_t      rsp,
   output aib_csr_pkg::aib_adapt_cfg_t cfg
);

   // Index 0 to 3 is rx_0, rx_1, tx_0, tx_1
   localparam logic [3:0][`AIB_CSR_AW-1:0] reg_addr = {
      `AIB_CSR_TX1_ADDR, `AIB_CSR_TX0_ADDR, `AIB_CSR_RX1_ADDR, `AIB_CSR_RX0_ADDR
   };
   localparam logic [3:0][31:0] reg_mask = {
      `AIB_CSR_TX1_MASK, `AIB_CSR_TX0_MASK, `AIB_CSR_RX1_MASK, `AIB_CSR_RX0_MASK
   };

   logic [3:0][31:0] regs;
   logic [3:0]       hit;
   logic [3:0][3:0]  we_byte;
   logic [31:0]      rdata_comb;

   // Offset decode and per-register byte write enables
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         hit[i]     = (bus_req.address == reg_addr[i]);
         we_byte[i] = (bus_req.write && hit[i]) ? bus_req.byteenable : 4'h0;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         regs <= '0;
      end else begin
         for (int i = 0; i < 4; i++) begin
            for (int b = 0; b < 4; b++) begin
               if (we_byte[i][b]) begin
                  regs[i][b*8 +: 8] <= bus_req.writedata[b*8 +: 8];
               end
            end
         end
      end
   end

   // Only implemented bits read back, unmapped offsets read zero
   always_comb begin
      rdata_comb = 32'h0;
      for (int i = 0; i < 4; i++) begin
         if (hit[i]) begin
            rdata_comb = regs[i] & reg_mask[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bus_req.read) begin
         rsp.readdata <= rdata_comb;
      end
   end

   // Read data is returned on the next cycle
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rsp.readdatavalid <= 1'b0;
      end else begin
         rsp.readdatavalid <= bus_req.read;
      end
   end

   assign cfg.rx_0 = regs[0];
   assign cfg.rx_1 = regs[1];
   assign cfg.tx_0 = regs[2];
   assign cfg.tx_1 = regs[3];

   a_rdv_one_cycle : assert property (@(posedge clk) disable iff (!reset_n)
      bus_req.read |=> rsp.readdatavalid ##1 !rsp.readdatavalid);

endmodule

`default_nettype wire

// File: source/aib_csr_top.sv
//////////////////////////////
// Adapter CSR subsystem top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aib_csr_config.svh"

module aib_csr_top (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic [`AIB_CSR_AW-1:0]      awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [31:0]                 wdata,
   input  logic [3:0]                  wstrb,
   input  logic                        wvalid,
   output logic                        wready,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [`AIB_CSR_AW-1:0]      araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [31:0]                 rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   output aib_csr_pkg::aib_adapt_cfg_t adapt_cfg,
   output logic                        cfg_done
);

   import aib_csr_pkg::*;

   avmm_req_t host_req;
   avmm_req_t boot_req;
   avmm_req_t bus_req;
   avmm_rsp_t rsp;
   logic      host_gnt;
   logic      boot_gnt;

   axil_avmm_bridge u_bridge (
      .clk, .reset_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .req (host_req), .gnt (host_gnt), .rsp
   );

   cfg_boot_loader u_boot (
      .clk, .reset_n, .req (boot_req), .gnt (boot_gnt), .cfg_done
   );

   avmm_arbiter u_arb (
      .clk, .reset_n, .host_req, .boot_req, .host_gnt, .boot_gnt, .bus_req, .rsp
   );

   aib_avmm_adapt_csr u_csr (
      .clk, .reset_n, .bus_req, .rsp, .cfg (adapt_cfg)
   );

endmodule

`default_nettype wire

// File: bench/tb_aib_csr.sv
//////////////////////////////
// Random-stimulus testbench with an AXI
// driver and a register model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aib_csr_config.svh"

module tb_aib_csr;

   import aib_csr_pkg::*;

   localparam int timeout_cycles = 100;

   // Index 0 to 3 is rx_0, rx_1, tx_0, tx_1
   localparam logic [3:0][`AIB_CSR_AW-1:0] reg_addr = {
      `AIB_CSR_TX1_ADDR, `AIB_CSR_TX0_ADDR, `AIB_CSR_RX1_ADDR, `AIB_CSR_RX0_ADDR
   };
   localparam logic [3:0][31:0] reg_mask = {
      `AIB_CSR_TX1_MASK, `AIB_CSR_TX0_MASK, `AIB_CSR_RX1_MASK, `AIB_CSR_RX0_MASK
   };

   logic                   clk;
   logic                   reset_n;
   logic [`AIB_CSR_AW-1:0] awaddr;
   logic                   awvalid;
   logic                   awready;
   logic [31:0]            wdata;
   logic [3:0]             wstrb;
   logic                   wvalid;
   logic                   wready;
   logic [1:0]             bresp;
   logic                   bvalid;
   logic                   bready;
   logic [`AIB_CSR_AW-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   logic [31:0]            rdata;
   logic [1:0]             rresp;
   logic                   rvalid;
   logic                   rready;
   aib_adapt_cfg_t         adapt_cfg;
   logic                   cfg_done;

   logic [3:0][31:0] model;
   logic [31:0]      rng;
   logic             timed_out = 1'b0;
   int               errors = 0;
   int               checks = 0;
   int               tests_run = 0;
   int               tests_bad = 0;

   aib_csr_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Expected adapt_cfg, in struct field order
   function automatic logic [127:0] model_cfg();
      return {model[0], model[1], model[2], model[3]};
   endfunction

   task automatic note_timeout(input string what, input int n);
      if (n >= timeout_cycles && !timed_out) begin
         $display("Timeout: %s did not arrive within %0d cycles", what, timeout_cycles);
         timed_out = 1'b1;
      end
   endtask

   task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
      if (!timed_out) begin
         checks++;
         if (act !== exp) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            errors++;
         end
      end
   endtask

   // One AXI4-Lite write or read, response held off for hold cycles
   task automatic axi_xfer(input logic wr, input logic [`AIB_CSR_AW-1:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input int hold, output logic [31:0] rd);
      int n;
      @(posedge clk);
      awaddr  <= addr;
      araddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= wr;
      wvalid  <= wr;
      arvalid <= !wr;
      @(negedge clk);
      for (n = 0; !(wr ? (awready && wready) : arready) && n < timeout_cycles; n++)
         @(negedge clk);
      note_timeout(wr ? "awready and wready" : "arready", n);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
      @(negedge clk);
      for (n = 0; !(wr ? bvalid : rvalid) && n < timeout_cycles; n++)
         @(negedge clk);
      note_timeout(wr ? "bvalid" : "rvalid", n);
      rd = rdata;
      // Valid and read data must hold while ready is low
      for (int i = 0; i < hold; i++) begin
         @(negedge clk);
         check("valid held", 1'b1, wr ? bvalid : rvalid);
         if (!wr)
            check("rdata stable", rd, rdata);
      end
      check("response code", 2'b00, wr ? bresp : rresp);
      @(posedge clk);
      bready <= wr;
      rready <= !wr;
      @(posedge clk);
      bready <= 1'b0;
      rready <= 1'b0;
      @(negedge clk);
   endtask

   task automatic finish_test(input string name, input int err0);
      tests_run++;
      if (timed_out || errors != err0)
         tests_bad++;
      $display("%s: %0d errors%s", name, errors - err0, timed_out ? ", timed out" : "");
   endtask

   task automatic test_boot();
      int          n;
      int          err0;
      logic [31:0] rd;
      err0 = errors;
      @(negedge clk);
      for (n = 0; !cfg_done && n < timeout_cycles; n++)
         @(negedge clk);
      note_timeout("cfg_done", n);
      check("boot adapt_cfg", model_cfg(), adapt_cfg);
      for (int i = 0; i < 4 && !timed_out; i++) begin
         axi_xfer(1'b0, reg_addr[i], 32'h0, 4'h0, 0, rd);
         check("boot read", model[i] & reg_mask[i], rd);
      end
      finish_test("boot", err0);
   endtask

   // Random writes to mapped offsets, each followed by a read-back
   task automatic test_writes(input string name, input logic rand_strb, input logic bp);
      int          err0;
      int          i;
      int          hold;
      logic [31:0] data;
      logic [3:0]  strb;
      logic [31:0] rd;
      err0 = errors;
      for (int k = 0; k < 16 && !timed_out; k++) begin
         rng = xorshift(rng);
         i = rng[1:0];
         hold = bp ? int'(rng[6:4]) + 1 : 0;
         strb = rand_strb ? rng[11:8] : 4'hf;
         rng = xorshift(rng);
         data = rng;
         axi_xfer(1'b1, reg_addr[i], data, strb, hold, rd);
         for (int b = 0; b < 4; b++) begin
            if (strb[b])
               model[i][b*8 +: 8] = data[b*8 +: 8];
         end
         check({name, " adapt_cfg"}, model_cfg(), adapt_cfg);
         axi_xfer(1'b0, reg_addr[i], 32'h0, 4'h0, hold, rd);
         check({name, " read"}, model[i] & reg_mask[i], rd);
      end
      finish_test(name, err0);
   endtask

   task automatic test_unmapped();
      int                     err0;
      logic [`AIB_CSR_AW-1:0] addr;
      logic [31:0]            rd;
      err0 = errors;
      for (int k = 0; k < 12 && !timed_out; k++) begin
         rng = xorshift(rng);
         addr = rng[`AIB_CSR_AW-1:0];
         // Mapped offsets all have bit 0 clear
         if (addr == reg_addr[0] || addr == reg_addr[1] || addr == reg_addr[2] ||
             addr == reg_addr[3])
            addr[0] = 1'b1;
         axi_xfer(1'b0, addr, 32'h0, 4'h0, 0, rd);
         check("unmapped read", 32'h0, rd);
         axi_xfer(1'b1, addr, xorshift(rng), 4'hf, 0, rd);
         check("unmapped write", model_cfg(), adapt_cfg);
      end
      finish_test("unmapped", err0);
   endtask

   initial begin
      reset_n = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      rng     = 32'h545a;
      model   = {`AIB_CSR_TX1_BOOT, `AIB_CSR_TX0_BOOT, `AIB_CSR_RX1_BOOT, `AIB_CSR_RX0_BOOT};
      repeat (2) @(posedge clk);
      reset_n <= 1'b1;
      test_boot();
      test_writes("full writes", 1'b0, 1'b0);
      test_writes("byte enables", 1'b1, 1'b0);
      test_unmapped();
      test_writes("back-pressure", 1'b1, 1'b1);
      $display("%0d tests, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_bad, checks, errors);
      if (errors == 0 && tests_bad == 0 && !timed_out)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/aib_csr_pkg.sv
source/axil_avmm_bridge.sv
source/cfg_boot_loader.sv
source/avmm_arbiter.sv
source/aib_avmm_adapt_csr.sv
source/aib_csr_top.sv
bench/tb_aib_csr.sv

// File: Bender.yml
package:
  name: aib_csr

sources:
  - include_dirs:
      - source
    files:
      - source/aib_csr_pkg.sv
      - source/axil_avmm_bridge.sv
      - source/cfg_boot_loader.sv
      - source/avmm_arbiter.sv
      - source/aib_avmm_adapt_csr.sv
      - source/aib_csr_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_aib_csr.sv
